//--- tb.f
+incdir+hdl
hdl/bpu_pkg.sv
hdl/predictor_unit.sv
hdl/branch_target_buffer.sv
hdl/branch_predictor.sv
bench/branch_predictor_checker.sv
bench/branch_predictor_tb.sv

//--- Makefile
# Verilator build and run for the branch prediction unit

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= branch_predictor_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/branch_predictor_tb.sv
// ----------------------------------------------------------------------
// Self-checking testbench for the branch prediction unit
// The DUT runs with 16 counters and 32 BTB entries, so two PCs can share
// a counter while they sit in different BTB slots
// A shadow of both tables predicts every output, cycle by cycle
// ----------------------------------------------------------------------

`include "bpu_macros.svh"

module branch_predictor_tb;

    localparam int          PRED_N      = 16;
    localparam int          BTB_N       = `BPU_BTB_SIZE;
    localparam int          MAX_CYCLES  = 5000;
    localparam int          RAND_CYCLES = 2000;
    localparam int unsigned SEED        = 32'hb3fc_adb9;

    // PC_A and PC_A2 share counter 0 but use BTB slots 0 and 16
    // PC_D aliases PC_A2 in BTB slot 16 with another tag, PC_J uses slot 1
    localparam bpu_pkg::bpu_addr_t PC_A  = 32'h0000_0100;
    localparam bpu_pkg::bpu_addr_t PC_A2 = 32'h0000_0140;
    localparam bpu_pkg::bpu_addr_t PC_D  = 32'h0000_1140;
    localparam bpu_pkg::bpu_addr_t PC_J  = 32'h0000_0204;

    // Small pool heavy on shared slots for the random stream
    localparam bpu_pkg::bpu_addr_t PC_POOL [8] = '{32'h0000_0100, 32'h0000_0140,
        32'h0000_1140, 32'h0000_0204, 32'h0000_1100, 32'h0000_2204, 32'h0000_0180,
        32'h0000_01c0};

    logic                  clk;
    logic                  rst_n;
    logic                  stall;
    logic                  mispredicted;
    bpu_pkg::bpu_addr_t    fetch_pc;
    bpu_pkg::bpu_resolve_t resolve;
    bpu_pkg::bpu_pred_t    pred;

    // Expected outputs and bookkeeping
    bpu_pkg::bpu_pred_t    exp_pred;
    logic                  exp_mis;
    int                    errors;
    int                    checks;
    int                    cycles;

    // Shadow tables where the BTB keeps the full PC in place of a tag
    logic                  sh_valid [BTB_N];
    bpu_pkg::bpu_addr_t    sh_pc    [BTB_N];
    bpu_pkg::bpu_addr_t    sh_tgt   [BTB_N];
    bpu_pkg::bpu_kind_e    sh_kind  [BTB_N];
    int                    sh_ctr   [PRED_N];

    branch_predictor #(
        .PREDICTOR_SIZE ( PRED_N ),
        .BTB_SIZE       ( BTB_N  )
    ) u_branch_predictor (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .fetch_pc_i     ( fetch_pc     ),
        .stall_i        ( stall        ),
        .resolve_i      ( resolve      ),
        .pred_o         ( pred         ),
        .mispredicted_o ( mispredicted )
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    // Prediction for one PC from the shadow with counters that count 0 to 3
    function automatic bpu_pkg::bpu_pred_t ref_predict(input bpu_pkg::bpu_addr_t pc);
        bpu_pkg::bpu_pred_t p;
        int                 b;
        int                 c;

        b = int'((pc >> 2) % BTB_N);
        c = int'((pc >> 2) % PRED_N);
        p.hit    = sh_valid[b] && (sh_pc[b][31:2] == pc[31:2]);
        p.taken  = p.hit && ((sh_kind[b] == bpu_pkg::KIND_JUMP) || (sh_ctr[c] >= 2));
        p.target = p.hit ? sh_tgt[b] : '0;
        return p;
    endfunction

    // Wrong direction, or taken both ways with a different target
    function automatic logic ref_mispredict(input bpu_pkg::bpu_resolve_t r);
        bpu_pkg::bpu_pred_t p;

        p = ref_predict(r.pc);
        return (p.taken != r.taken) || (r.taken && (p.target != r.target));
    endfunction

    task automatic shadow_update(input bpu_pkg::bpu_resolve_t r);
        int b;
        int c;

        b = int'((r.pc >> 2) % BTB_N);
        c = int'((r.pc >> 2) % PRED_N);
        if (r.valid && r.taken) begin
            sh_valid[b] = 1'b1;
            sh_pc[b]    = r.pc;
            sh_tgt[b]   = r.target;
            sh_kind[b]  = r.kind;
        end
        if (r.valid && (r.kind == bpu_pkg::KIND_BRANCH)) begin
            if (r.taken && (sh_ctr[c] < 3)) sh_ctr[c] = sh_ctr[c] + 1;
            else if (!r.taken && (sh_ctr[c] > 0)) sh_ctr[c] = sh_ctr[c] - 1;
        end
    endtask

    // Reads the inputs the DUT samples at this edge, before the new drive lands
    always @(posedge clk) begin : reference_model
        if (!rst_n) begin
            for (int i = 0; i < BTB_N; i++) sh_valid[i] = 1'b0;
            for (int i = 0; i < PRED_N; i++) sh_ctr[i] = 1;
            exp_pred = '0;
            exp_mis  = 1'b0;
        end else begin
            exp_mis = resolve.valid && ref_mispredict(resolve);
            if (!stall) exp_pred = ref_predict(fetch_pc);
            shadow_update(resolve);
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin : compare_outputs
        checks = checks + 2;
        assert (pred === exp_pred) else begin
            errors = errors + 1;
            $display("MISMATCH at %0t: pred_o expected %h got %h", $time, exp_pred, pred);
        end
        assert (mispredicted === exp_mis) else begin
            errors = errors + 1;
            $display("MISMATCH at %0t: mispredicted_o expected %b got %b",
                     $time, exp_mis, mispredicted);
        end
    end

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------

    task automatic drive(input bpu_pkg::bpu_addr_t pc, input logic st,
                         input bpu_pkg::bpu_resolve_t r);
        @(posedge clk);
        fetch_pc <= pc;
        stall    <= st;
        resolve  <= r;
    endtask

    function automatic bpu_pkg::bpu_resolve_t make_resolve(input bpu_pkg::bpu_addr_t pc,
        input bpu_pkg::bpu_addr_t target, input logic taken, input bpu_pkg::bpu_kind_e kind);
        bpu_pkg::bpu_resolve_t r;

        r.valid  = 1'b1;
        r.pc     = pc;
        r.target = target;
        r.taken  = taken;
        r.kind   = kind;
        return r;
    endfunction

    // Compares pred_o with fixed values worked out by hand from the rules
    task automatic check_pred(input logic hit, input logic taken,
                              input bpu_pkg::bpu_addr_t target);
        bpu_pkg::bpu_pred_t want;

        want.hit    = hit;
        want.taken  = taken;
        want.target = target;
        checks = checks + 1;
        assert (pred === want) else begin
            errors = errors + 1;
            $display("MISMATCH at %0t: pred_o expected %h got %h", $time, want, pred);
        end
    endtask

    task automatic fetch_check(input bpu_pkg::bpu_addr_t pc, input logic hit,
                               input logic taken, input bpu_pkg::bpu_addr_t target);
        drive(pc, 1'b0, '0);
        @(posedge clk);
        @(negedge clk);
        check_pred(hit, taken, target);
    endtask

    // One strobe, then the pulse is read in the cycle after its edge
    task automatic resolve_check(input bpu_pkg::bpu_addr_t pc, input bpu_pkg::bpu_addr_t target,
                                 input logic taken, input bpu_pkg::bpu_kind_e kind,
                                 input logic mis);
        drive(fetch_pc, 1'b0, make_resolve(pc, target, taken, kind));
        @(posedge clk);
        resolve.valid <= 1'b0;
        @(negedge clk);
        checks = checks + 1;
        assert (mispredicted === mis) else begin
            errors = errors + 1;
            $display("MISMATCH at %0t: mispredicted_o expected %b got %b",
                     $time, mis, mispredicted);
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin : main
        bpu_pkg::bpu_resolve_t rs;
        logic [31:0]           r;
        logic [31:0]           r2;
        int                    assert_fails;

        r        = $urandom(SEED);
        clk      = 1'b0;
        rst_n    = 1'b0;
        stall    = 1'b0;
        fetch_pc = '0;
        resolve  = '0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Cold tables miss everywhere, so the first taken branch is a mispredict
        fetch_check(PC_A, 1'b0, 1'b0, '0);
        resolve_check(PC_A, 32'h0000_3000, 1'b1, bpu_pkg::KIND_BRANCH, 1'b1);

        // Jump learning and target replacement
        resolve_check(PC_J, 32'h0000_4000, 1'b1, bpu_pkg::KIND_JUMP, 1'b1);
        fetch_check(PC_J, 1'b1, 1'b1, 32'h0000_4000);
        resolve_check(PC_J, 32'h0000_5000, 1'b1, bpu_pkg::KIND_JUMP, 1'b1);
        fetch_check(PC_J, 1'b1, 1'b1, 32'h0000_5000);

        // Counter 0 goes to STRONG_T, then back down one state at a time
        resolve_check(PC_A, 32'h0000_3000, 1'b1, bpu_pkg::KIND_BRANCH, 1'b0);
        resolve_check(PC_A, 32'h0000_3000, 1'b1, bpu_pkg::KIND_BRANCH, 1'b0);
        resolve_check(PC_A, 32'h0000_3000, 1'b0, bpu_pkg::KIND_BRANCH, 1'b1);
        fetch_check(PC_A, 1'b1, 1'b1, 32'h0000_3000);
        resolve_check(PC_A, 32'h0000_3000, 1'b0, bpu_pkg::KIND_BRANCH, 1'b1);
        fetch_check(PC_A, 1'b1, 1'b0, 32'h0000_3000);

        // A jump on counter 0 leaves PC_A predicting not taken
        resolve_check(PC_D, 32'h0000_6000, 1'b1, bpu_pkg::KIND_JUMP, 1'b1);
        fetch_check(PC_A, 1'b1, 1'b0, 32'h0000_3000);
        fetch_check(PC_D, 1'b1, 1'b1, 32'h0000_6000);

        // PC_A2 evicts PC_D and trains the counter it shares with PC_A
        resolve_check(PC_A2, 32'h0000_7000, 1'b1, bpu_pkg::KIND_BRANCH, 1'b1);
        fetch_check(PC_D, 1'b0, 1'b0, '0);
        fetch_check(PC_A, 1'b1, 1'b1, 32'h0000_3000);
        fetch_check(PC_A2, 1'b1, 1'b1, 32'h0000_7000);

        // Stall holds pred_o while the PC moves and the PC_J entry is rewritten
        fetch_check(PC_J, 1'b1, 1'b1, 32'h0000_5000);
        drive(PC_A, 1'b1, make_resolve(PC_J, 32'h0000_9000, 1'b1, bpu_pkg::KIND_JUMP));
        drive(PC_A2, 1'b1, '0);
        @(posedge clk);
        @(negedge clk);
        check_pred(1'b1, 1'b1, 32'h0000_5000);
        drive(PC_J, 1'b0, '0);
        @(posedge clk);
        @(negedge clk);
        check_pred(1'b1, 1'b1, 32'h0000_9000);

        // Random stream that the comparing process checks every cycle
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r         = $urandom;
            r2        = $urandom;
            rs.valid  = r[0];
            rs.pc     = PC_POOL[r[3:1]];
            rs.target = {28'h000_0800, r2[1:0], 2'b00};
            rs.taken  = r[4];
            rs.kind   = (r[6:5] == 2'b00) ? bpu_pkg::KIND_JUMP : bpu_pkg::KIND_BRANCH;
            drive(PC_POOL[r[9:7]], r[12:10] == 3'b000, rs);
        end

        // The last falling edge compare is complete by the next rising edge
        drive(PC_A, 1'b0, '0);
        @(posedge clk);
        @(negedge clk);
        @(posedge clk);
        assert_fails = u_branch_predictor.u_checker.fail_count;
        $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : branch_predictor_tb

//--- bench/branch_predictor_checker.sv
// ----------------------------------------------------------------------
// Protocol assertions bound to the branch prediction top level
// All but the reset check are disabled while rst_n_i is low
// ----------------------------------------------------------------------

module branch_predictor_checker (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input bpu_pkg::bpu_resolve_t resolve_i,
    input bpu_pkg::bpu_pred_t    pred_o,
    input logic                  mispredicted_o
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Nothing is predicted taken without a BTB hit to supply the target
    a_taken_needs_hit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pred_o.taken |-> pred_o.hit)
        else begin
            fail_count++;
            $error("pred_o.taken is set while pred_o.hit is clear");
        end

    // The pulse always answers a strobe sampled one edge earlier
    a_mispredict_after_resolve : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mispredicted_o |-> $past(resolve_i.valid))
        else begin
            fail_count++;
            $error("mispredicted_o is high without a resolve strobe one cycle before");
        end

    // From the second reset edge on, both outputs sit at zero
    a_reset_outputs_zero : assert property (@(posedge clk_i)
        (!rst_n_i && !$past(rst_n_i)) |-> ((pred_o == '0) && !mispredicted_o))
        else begin
            fail_count++;
            $error("outputs are not zero while reset is held");
        end

endmodule : branch_predictor_checker

bind branch_predictor branch_predictor_checker u_checker (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .resolve_i      ( resolve_i      ),
    .pred_o         ( pred_o         ),
    .mispredicted_o ( mispredicted_o )
);

//--- hdl/branch_predictor.sv
// ----------------------------------------------------------------------
// Branch prediction unit, combining the BTB and the direction counters
// pred_o follows fetch_pc_i by one cycle and holds while stall_i is high
// Table updates go ahead regardless of stall_i
// The mispredict pulse is recomputed from the tables at resolve time
// ----------------------------------------------------------------------

`include "bpu_macros.svh"

module branch_predictor #(
    // Direction counter table depth
    parameter int PREDICTOR_SIZE = `BPU_PRED_SIZE,

    // Branch target buffer depth
    parameter int BTB_SIZE = `BPU_BTB_SIZE
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Fetch stage
    input  bpu_pkg::bpu_addr_t    fetch_pc_i,
    input  logic                  stall_i,

    // Execute stage outcome
    input  bpu_pkg::bpu_resolve_t resolve_i,

    // Registered prediction and mispredict pulse
    output bpu_pkg::bpu_pred_t    pred_o,
    output logic                  mispredicted_o
);

    // ------------------------------------------------------------------
    // Tables
    // ------------------------------------------------------------------

    bpu_pkg::bpu_btb_rd_t lookup_rd;
    bpu_pkg::bpu_btb_rd_t resolve_rd;
    logic                 lookup_ctr_taken;
    logic                 resolve_ctr_taken;
    bpu_pkg::bpu_pred_t   lookup_pred;
    bpu_pkg::bpu_pred_t   resolve_pred;
    logic                 mispredict_d;

    predictor_unit #(
        .PREDICTOR_SIZE ( PREDICTOR_SIZE )
    ) u_predictor_unit (
        .clk_i           ( clk_i             ),
        .rst_n_i         ( rst_n_i           ),
        .lookup_pc_i     ( fetch_pc_i        ),
        .lookup_taken_o  ( lookup_ctr_taken  ),
        .resolve_i       ( resolve_i         ),
        .resolve_taken_o ( resolve_ctr_taken )
    );

    branch_target_buffer #(
        .BTB_SIZE ( BTB_SIZE )
    ) u_branch_target_buffer (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .lookup_pc_i  ( fetch_pc_i ),
        .lookup_o     ( lookup_rd  ),
        .resolve_i    ( resolve_i  ),
        .resolve_rd_o ( resolve_rd )
    );

    // ------------------------------------------------------------------
    // Prediction rule
    // ------------------------------------------------------------------

    // Jumps are always taken on a hit, branches follow their counter
    // Without a BTB hit there is no target, so nothing is predicted taken
    // The BTB already zeroes the target on a miss
    function automatic bpu_pkg::bpu_pred_t combine(input bpu_pkg::bpu_btb_rd_t rd,
                                                   input logic                 ctr_taken);
        bpu_pkg::bpu_pred_t pred;

        pred.hit    = rd.hit;
        pred.taken  = rd.hit && ((rd.kind == bpu_pkg::KIND_JUMP) || ctr_taken);
        pred.target = rd.target;
        return pred;
    endfunction

    assign lookup_pred  = combine(lookup_rd, lookup_ctr_taken);

    // Same rule applied to the resolved PC, as fetch would have seen it
    assign resolve_pred = combine(resolve_rd, resolve_ctr_taken);

    // ------------------------------------------------------------------
    // Mispredict rule
    // ------------------------------------------------------------------

    // Wrong direction, or right direction with a stale target
    always_comb begin : mispredict_rule
        mispredict_d = 1'b0;
        if (resolve_i.valid) begin
            if (resolve_pred.taken != resolve_i.taken) begin
                mispredict_d = 1'b1;
            end else if (resolve_i.taken && (resolve_pred.target != resolve_i.target)) begin
                mispredict_d = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------------

    // Stall only freezes the prediction, never the mispredict pulse
    always_ff @(posedge clk_i or negedge rst_n_i) begin : output_regs
        if (!rst_n_i) begin
            pred_o         <= '0;
            mispredicted_o <= 1'b0;
        end else begin
            if (!stall_i) begin
                pred_o <= lookup_pred;
            end
            mispredicted_o <= mispredict_d;
        end
    end

endmodule : branch_predictor

//--- hdl/branch_target_buffer.sv
// ----------------------------------------------------------------------
// Direct-mapped tagged branch target buffer
// BTB_SIZE must be a power of two and at least 2
// Only taken resolves allocate, a not-taken branch leaves it unchanged
// Reads are combinational and show the contents before the edge
// Kind is reported raw on a miss, only the target is forced to zero
// ----------------------------------------------------------------------

`include "bpu_macros.svh"

module branch_target_buffer #(
    // Number of entries
    parameter int BTB_SIZE = `BPU_BTB_SIZE
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Fetch side lookup
    input  bpu_pkg::bpu_addr_t    lookup_pc_i,
    output bpu_pkg::bpu_btb_rd_t  lookup_o,

    // Resolve side read and allocation
    input  bpu_pkg::bpu_resolve_t resolve_i,
    output bpu_pkg::bpu_btb_rd_t  resolve_rd_o
);

    // Index sits above the byte offset, the tag takes every bit above it
    localparam int IDX_W = $clog2(BTB_SIZE);
    localparam int TAG_W = `BPU_XLEN - 2 - IDX_W;

    // ------------------------------------------------------------------
    // Entry storage
    // ------------------------------------------------------------------

    logic               valid_q  [BTB_SIZE];
    logic [TAG_W-1:0]   tag_q    [BTB_SIZE];
    bpu_pkg::bpu_addr_t target_q [BTB_SIZE];
    bpu_pkg::bpu_kind_e kind_q   [BTB_SIZE];

    logic [IDX_W-1:0] resolve_idx;
    logic [TAG_W-1:0] resolve_tag;
    logic             alloc_en;

    assign resolve_idx = resolve_i.pc[2 +: IDX_W];
    assign resolve_tag = resolve_i.pc[2 + IDX_W +: TAG_W];

    // Any taken control instruction claims its slot
    assign alloc_en = resolve_i.valid && resolve_i.taken;

    // ------------------------------------------------------------------
    // Read ports
    // ------------------------------------------------------------------

    // Shared lookup used by both ports
    // A hit needs a valid entry whose stored tag equals the address tag
    function automatic bpu_pkg::bpu_btb_rd_t read_entry(input bpu_pkg::bpu_addr_t pc);
        logic [IDX_W-1:0]     idx;
        logic [TAG_W-1:0]     tag;
        bpu_pkg::bpu_btb_rd_t rd;

        idx       = pc[2 +: IDX_W];
        tag       = pc[2 + IDX_W +: TAG_W];
        rd.hit    = valid_q[idx] && (tag_q[idx] == tag);
        rd.kind   = kind_q[idx];
        rd.target = rd.hit ? target_q[idx] : '0;
        return rd;
    endfunction

    // Fetch side port, registered later by the top level
    always_comb begin : lookup_port
        lookup_o = read_entry(lookup_pc_i);
    end

    // Resolve side port, used to judge the prediction that fetch would have made
    always_comb begin : resolve_port
        resolve_rd_o = read_entry(resolve_i.pc);
    end

    // ------------------------------------------------------------------
    // Allocation
    // ------------------------------------------------------------------

    // Valid bits are the only state that must start known
    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_update
        if (!rst_n_i) begin
            for (int i = 0; i < BTB_SIZE; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (alloc_en) begin
            valid_q[resolve_idx] <= 1'b1;
        end
    end

    // Payload is written whole, so a different tag simply evicts the
    // older entry in the same slot
    always_ff @(posedge clk_i) begin : payload_update
        if (alloc_en) begin
            tag_q[resolve_idx]    <= resolve_tag;
            target_q[resolve_idx] <= resolve_i.target;
            kind_q[resolve_idx]   <= resolve_i.kind;
        end
    end

endmodule : branch_target_buffer

//--- hdl/predictor_unit.sv
// ----------------------------------------------------------------------
// Direction table of 2-bit saturating counters, indexed by PC[2 +: n]
// PREDICTOR_SIZE must be a power of two and at least 2
// Both reads are combinational, with no output registers
// A read of the entry being updated returns the value before the edge
// Jumps never touch the counters
// ----------------------------------------------------------------------

`include "bpu_macros.svh"

module predictor_unit #(
    // Number of counters in the table
    parameter int PREDICTOR_SIZE = `BPU_PRED_SIZE
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    // Fetch side lookup
    input  bpu_pkg::bpu_addr_t    lookup_pc_i,
    output logic                  lookup_taken_o,

    // Resolve side read and update
    input  bpu_pkg::bpu_resolve_t resolve_i,
    output logic                  resolve_taken_o
);

    // Number of PC bits that select a counter
    localparam int IDX_W = $clog2(PREDICTOR_SIZE);

    // ------------------------------------------------------------------
    // Storage and indexing
    // ------------------------------------------------------------------

    bpu_pkg::bpu_ctr_e ctr_q [PREDICTOR_SIZE];

    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] resolve_idx;
    logic             update_en;

    // Word aligned addresses, so the index starts above the byte offset
    assign lookup_idx  = lookup_pc_i[2 +: IDX_W];
    assign resolve_idx = resolve_i.pc[2 +: IDX_W];

    // Only conditional branches train the counters
    assign update_en = resolve_i.valid && (resolve_i.kind == bpu_pkg::KIND_BRANCH);

    // ------------------------------------------------------------------
    // Counter helpers
    // ------------------------------------------------------------------

    // A counter votes taken in its two upper states
    function automatic logic ctr_taken(input bpu_pkg::bpu_ctr_e ctr);
        return (ctr == bpu_pkg::WEAK_T) || (ctr == bpu_pkg::STRONG_T);
    endfunction

    // Move one state toward the outcome and stick at either end
    function automatic bpu_pkg::bpu_ctr_e ctr_step(input bpu_pkg::bpu_ctr_e ctr,
                                                   input logic              taken);
        bpu_pkg::bpu_ctr_e nxt;

        nxt = ctr;
        case (ctr)
            bpu_pkg::STRONG_NT: nxt = taken ? bpu_pkg::WEAK_NT  : bpu_pkg::STRONG_NT;
            bpu_pkg::WEAK_NT:   nxt = taken ? bpu_pkg::WEAK_T   : bpu_pkg::STRONG_NT;
            bpu_pkg::WEAK_T:    nxt = taken ? bpu_pkg::STRONG_T : bpu_pkg::WEAK_NT;
            bpu_pkg::STRONG_T:  nxt = taken ? bpu_pkg::STRONG_T : bpu_pkg::WEAK_T;
            // Unreachable with a 2-bit enum, falls back to the reset state
            default:            nxt = bpu_pkg::WEAK_NT;
        endcase
        return nxt;
    endfunction

    // ------------------------------------------------------------------
    // Read ports
    // ------------------------------------------------------------------

    // Both ports see the table as it was before the current edge
    assign lookup_taken_o  = ctr_taken(ctr_q[lookup_idx]);
    assign resolve_taken_o = ctr_taken(ctr_q[resolve_idx]);

    // ------------------------------------------------------------------
    // Update port
    // ------------------------------------------------------------------

    // Every counter starts weakly not taken, so one taken outcome flips it
    always_ff @(posedge clk_i or negedge rst_n_i) begin : counter_update
        if (!rst_n_i) begin
            for (int i = 0; i < PREDICTOR_SIZE; i++) begin
                ctr_q[i] <= bpu_pkg::WEAK_NT;
            end
        end else if (update_en) begin
            ctr_q[resolve_idx] <= ctr_step(ctr_q[resolve_idx], resolve_i.taken);
        end
    end

endmodule : predictor_unit

//--- hdl/bpu_pkg.sv
// ----------------------------------------------------------------------
// Types shared by the branch prediction RTL and its testbench
// Field order inside the structs sets the packed bit layout
// ----------------------------------------------------------------------

`include "bpu_macros.svh"

package bpu_pkg;

    // One address word, used for PCs and branch targets
    typedef logic [`BPU_XLEN-1:0] bpu_addr_t;

    // Kind of control instruction seen at resolve time
    typedef enum logic {
        KIND_BRANCH = 1'b0,
        KIND_JUMP   = 1'b1
    } bpu_kind_e;

    // Saturating counter states, in counting order
    // The upper two states predict taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } bpu_ctr_e;

    // Resolve strobe from the execute stage
    typedef struct packed {
        logic      valid;
        bpu_addr_t pc;
        bpu_addr_t target;
        logic      taken;
        bpu_kind_e kind;
    } bpu_resolve_t;

    // Prediction handed to the fetch stage
    typedef struct packed {
        logic      hit;
        logic      taken;
        bpu_addr_t target;
    } bpu_pred_t;

    // Result of one BTB read port
    typedef struct packed {
        logic      hit;
        bpu_kind_e kind;
        bpu_addr_t target;
    } bpu_btb_rd_t;

endpackage : bpu_pkg

//--- hdl/bpu_macros.svh
// ----------------------------------------------------------------------
// Global sizes of the branch prediction unit
// Table depths must be powers of two and at least 2
// Addresses are word aligned, so PC bits [1:0] never index a table
// ----------------------------------------------------------------------

`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// Width of every PC and every target address
`define BPU_XLEN 32

// Default number of 2-bit direction counters
`define BPU_PRED_SIZE 32

// Default number of direct-mapped BTB entries
`define BPU_BTB_SIZE 32

`endif
